/* list.f */
bridge_pkg.sv
sram_ctrl.sv
ram_addr_path.sv
ram_write_path.sv
ram_read_latch.sv
sram_bridge_top.sv
tb_sram_model.sv
tb_sram_bridge.sv

/* run.sh */
#!/bin/sh
# build and run the sram bridge testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    -f list.f --top-module tb_sram_bridge -o tb_sram_bridge
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sram_bridge)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Simulation passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* tb_sram_bridge.sv */
module tb_sram_bridge import bridge_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // one table row for the fetch port, the data port or both
    typedef struct packed {
        logic              use_if;
        logic [ADDR_W-1:0] if_addr;
        logic              use_mem;
        data_req_t         req;
    } step_t;

    logic              clk_uart_in = 1'b0;
    logic              rst_i;
    logic              if_ce;
    logic [ADDR_W-1:0] if_addr;
    logic [DATA_W-1:0] if_data;
    logic              if_done;
    logic              mem_ce;
    data_req_t         mem_req;
    logic [DATA_W-1:0] mem_data;
    logic              mem_done;
    ram_cmd_t          ram_cmd;
    logic [DATA_W-1:0] dq_to_ram;
    logic              dq_oe;
    logic [DATA_W-1:0] dq_from_ram;

    logic [DATA_W-1:0] shadow [2**ADDR_W];  // expected ram contents
    step_t             steps[$];
    string             names[$];
    int                checks = 0;
    int                value_errs = 0;
    int                other_errs = 0;
    int                cyc = 0;
    int                last_done_cyc = 0;
    logic              gap_valid = 1'b0;
    logic              timed_out = 1'b0;
    logic              have_if = 1'b0;
    logic [DATA_W-1:0] last_if = '0;       // last word the fetch port got
    logic [31:0]       rng_state = 32'd85834;

    always #4 clk_uart_in = ~clk_uart_in;

    always @(posedge clk_uart_in) begin
        cyc <= cyc + 1;
    end

    sram_bridge_top DUT (
        .clk_uart_in (clk_uart_in),
        .rst_i       (rst_i),
        .if_ce_i     (if_ce),
        .if_addr_i   (if_addr),
        .if_data_o   (if_data),
        .if_done_o   (if_done),
        .mem_ce_i    (mem_ce),
        .mem_req_i   (mem_req),
        .mem_data_o  (mem_data),
        .mem_done_o  (mem_done),
        .ram_cmd_o   (ram_cmd),
        .ram_dq_o    (dq_to_ram),
        .ram_dq_oe_o (dq_oe),
        .ram_dq_i    (dq_from_ram)
    );

    tb_sram_model u_sram (
        .clk_uart_in (clk_uart_in),
        .cmd_i       (ram_cmd),
        .dq_i        (dq_to_ram),
        .dq_oe_i     (dq_oe),
        .dq_o        (dq_from_ram)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // every address bit shows up in the word
    function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
        return {a[11:0], a} ^ 32'h9e37_79b9;
    endfunction

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
            input logic [DATA_W-1:0] new_w, input logic [BE_W-1:0] be);
        logic [DATA_W-1:0] w;
        w = old_w;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                w[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return w;
    endfunction

    function automatic step_t make_step(input logic use_if, input logic [ADDR_W-1:0] fa,
            input logic use_mem, input logic [ADDR_W-1:0] da, input logic [BE_W-1:0] be,
            input logic [DATA_W-1:0] wd, input logic we);
        step_t s;
        s.use_if  = use_if;
        s.if_addr = fa;
        s.use_mem = use_mem;
        s.req     = '{addr: da, be: be, wdata: wd, we: we};
        return s;
    endfunction

    task automatic add_step(input string name, input step_t s);
        names.push_back(name);
        steps.push_back(s);
    endtask

    task automatic report_mismatch(input string name, input string what,
            input logic [31:0] exp_v, input logic [31:0] act_v);
        value_errs++;
        $display("ERR %s %s expected %08h actual %08h", name, what, exp_v, act_v);
    endtask

    // strobes parked and bus released with no done pulse
    task automatic check_idle(input string name);
        logic [31:0] seen;
        seen = {22'd0, ram_cmd.be_n, ram_cmd.ce_n, ram_cmd.oe_n, ram_cmd.we_n,
                dq_oe, if_done, mem_done};
        checks++;
        if (seen !== 32'h0000_03f8) report_mismatch(name, "idle pins", 32'h0000_03f8, seen);
    endtask

    // pins during the single command cycle of one access
    task automatic check_command(input string name, input step_t s, input logic is_mem);
        logic              wr;
        logic [ADDR_W-1:0] exp_addr;
        logic [31:0]       exp_pins;
        logic [31:0]       seen;
        wr       = is_mem && s.req.we;
        exp_addr = is_mem ? s.req.addr : s.if_addr;
        // lanes are active low and a fetch enables all of them
        exp_pins = {24'd0, (is_mem ? ~s.req.be : 4'h0), 1'b0, wr, !wr, wr};
        seen     = {24'd0, ram_cmd.be_n, ram_cmd.ce_n, ram_cmd.oe_n, ram_cmd.we_n, dq_oe};
        checks += 2;
        if (seen !== exp_pins) report_mismatch(name, "command pins", exp_pins, seen);
        if (ram_cmd.addr !== exp_addr) begin
            report_mismatch(name, "ram addr", {12'd0, exp_addr}, {12'd0, ram_cmd.addr});
        end
        if (wr) begin
            checks++;
            if (dq_to_ram !== s.req.wdata) begin
                report_mismatch(name, "ram wdata", s.req.wdata, dq_to_ram);
            end
        end
    endtask

    // back-to-back traffic puts done pulses 4 cycles apart
    task automatic note_done(input string name);
        checks++;
        if (gap_valid && cyc - last_done_cyc != 4) begin
            report_mismatch(name, "pulse spacing", 32'd4, cyc - last_done_cyc);
        end
        last_done_cyc = cyc;
        gap_valid = 1'b1;
    endtask

    task automatic do_access(input string name, input step_t s);
        int                n;
        logic              got_mem;
        logic              got_if;
        logic [DATA_W-1:0] exp_mem;
        logic [DATA_W-1:0] exp_if;

        // data port goes first so the fetch sees its write
        exp_mem = shadow[s.req.addr];
        if (s.use_mem && s.req.we) begin
            shadow[s.req.addr] = merge_bytes(shadow[s.req.addr], s.req.wdata, s.req.be);
        end
        exp_if = shadow[s.if_addr];

        if_ce   = s.use_if;
        if_addr = s.if_addr;
        mem_ce  = s.use_mem;
        mem_req = s.req;
        got_mem = !s.use_mem;
        got_if  = !s.use_if;
        n = 0;
        while (!(got_mem && got_if) && n < 20) begin
            @(negedge clk_uart_in);
            n++;
            if (n == 2) begin
                check_command(name, s, s.use_mem);
            end else if (n == 6 && s.use_mem && s.use_if) begin
                check_command(name, s, 1'b0);
            end else if (n == 3) begin
                checks++;
                if (ram_cmd.ce_n !== 1'b0 || ram_cmd.we_n !== 1'b1) begin
                    report_mismatch(name, "strobes after command", 32'h1,
                                    {30'd0, ram_cmd.ce_n, ram_cmd.we_n});
                end
            end
            if (mem_done && got_mem) begin
                other_errs++;
                $display("%s: unexpected mem_done pulse %0d cycles after the request",
                         name, n);
            end else if (mem_done) begin
                got_mem = 1'b1;
                mem_ce  = 1'b0;  // dropped inside the pulse cycle
                note_done(name);
                checks += 3;
                if (n != 4) report_mismatch(name, "mem latency", 32'd4, n);
                if (!s.req.we && mem_data !== exp_mem) begin
                    report_mismatch(name, "mem_data", exp_mem, mem_data);
                end
                if (have_if && if_data !== last_if) begin
                    report_mismatch(name, "if_data", last_if, if_data);
                end
            end
            if (if_done && got_if) begin
                other_errs++;
                $display("%s: unexpected if_done pulse %0d cycles after the request",
                         name, n);
            end else if (if_done) begin
                got_if = 1'b1;
                if_ce  = 1'b0;
                note_done(name);
                checks += 2;
                if (n != (s.use_mem ? 8 : 4)) begin
                    report_mismatch(name, "if latency", s.use_mem ? 32'd8 : 32'd4, n);
                end
                if (if_data !== exp_if) report_mismatch(name, "if_data", exp_if, if_data);
                last_if = exp_if;
                have_if = 1'b1;
            end
        end
        if (!(got_mem && got_if)) begin
            other_errs++;
            timed_out = 1'b1;
            if_ce  = 1'b0;
            mem_ce = 1'b0;
            $display("%s: no done pulse within 20 cycles, request abandoned", name);
        end
    endtask

    task automatic build_table();
        add_step("fetch_0",   make_step(1'b1, 20'h00010, 1'b0, '0, '0, '0, 1'b0));
        add_step("fetch_1",   make_step(1'b1, 20'h00011, 1'b0, '0, '0, '0, 1'b0));
        add_step("wr_lo",     make_step(1'b0, '0, 1'b1, 20'h00020, 4'b0011, 32'hdead_beef, 1'b1));
        add_step("rd_lo",     make_step(1'b0, '0, 1'b1, 20'h00020, 4'hf, '0, 1'b0));
        add_step("wr_mid",    make_step(1'b0, '0, 1'b1, 20'h00020, 4'b0110, 32'h1122_3344, 1'b1));
        add_step("rd_mid",    make_step(1'b0, '0, 1'b1, 20'h00020, 4'hf, '0, 1'b0));
        add_step("wr_full",   make_step(1'b0, '0, 1'b1, 20'h00030, 4'hf, 32'hcafe_f00d, 1'b1));
        add_step("arb_rd",    make_step(1'b1, 20'h00010, 1'b1, 20'h00030, 4'hf, '0, 1'b0));
        add_step("arb_wr",    make_step(1'b1, 20'h00040, 1'b1, 20'h00040, 4'b1001,
                                        32'h0bad_cafe, 1'b1));
        add_step("fetch_top", make_step(1'b1, 20'hfffff, 1'b0, '0, '0, '0, 1'b0));
        add_step("rd_top",    make_step(1'b0, '0, 1'b1, 20'hfffff, 4'hf, '0, 1'b0));
    endtask

    initial begin
        int                k;
        logic [31:0]       r;
        logic [ADDR_W-1:0] wa;
        step_t             s;

        rst_i   = 1'b1;
        if_ce   = 1'b0;
        if_addr = '0;
        mem_ce  = 1'b0;
        mem_req = '0;
        for (int a = 0; a < 2**ADDR_W; a++) begin
            wa = a[ADDR_W-1:0];
            shadow[wa] = fill_word(wa);
            u_sram.preload_word(wa, shadow[wa]);
        end
        build_table();

        repeat (16) begin
            @(negedge clk_uart_in);
            check_idle("reset");
        end
        rst_i = 1'b0;
        repeat (3) begin
            @(negedge clk_uart_in);
            check_idle("after_reset");
        end

        for (int i = 0; i < steps.size() && !timed_out; i++) begin
            do_access(names[i], steps[i]);
        end

        // small window so reads hit earlier writes
        for (k = 0; k < 40 && !timed_out; k++) begin
            r  = next_rand();
            wa = {16'h0010, r[7:4]};
            case (r[1:0])
                2'd0:    s = make_step(1'b1, wa, 1'b0, '0, '0, '0, 1'b0);
                2'd1:    s = make_step(1'b0, '0, 1'b1, wa, 4'hf, '0, 1'b0);
                default: s = make_step(1'b0, '0, 1'b1, wa, r[11:8], next_rand(), 1'b1);
            endcase
            do_access($sformatf("rnd_%0d", k), s);
        end

        repeat (4) begin
            @(negedge clk_uart_in);
            check_idle("tail");
        end

        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* tb_sram_model.sv */
module tb_sram_model import bridge_pkg::*; (
    input  logic              clk_uart_in,
    input  ram_cmd_t          cmd_i,
    input  logic [DATA_W-1:0] dq_i,
    input  logic              dq_oe_i,
    output logic [DATA_W-1:0] dq_o
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [DATA_W-1:0] mem [2**ADDR_W];
    logic [DATA_W-1:0] merged;

    // async read, bus reads as zero while the chip is not driving
    assign dq_o = (!cmd_i.ce_n && !cmd_i.oe_n) ? mem[cmd_i.addr] : '0;

    // write commits at the edge that ends the we_n low cycle
    always @(posedge clk_uart_in) begin
        if (!cmd_i.ce_n && !cmd_i.we_n && dq_oe_i) begin
            merged = mem[cmd_i.addr];
            for (int b = 0; b < BE_W; b++) begin
                if (!cmd_i.be_n[b]) begin
                    merged[8*b +: 8] = dq_i[8*b +: 8];  // active-low lane select
                end
            end
            mem[cmd_i.addr] = merged;
        end
    end

    // backdoor load before the first access
    task automatic preload_word(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        mem[a] = d;
    endtask

endmodule

/* sram_bridge_top.sv */
module sram_bridge_top import bridge_pkg::*; (
    input  logic              clk_uart_in,
    input  logic              rst_i,

    // instruction fetch port
    input  logic              if_ce_i,
    input  logic [ADDR_W-1:0] if_addr_i,
    output logic [DATA_W-1:0] if_data_o,
    output logic              if_done_o,

    // data port
    input  logic              mem_ce_i,
    input  data_req_t         mem_req_i,
    output logic [DATA_W-1:0] mem_data_o,
    output logic              mem_done_o,

    // base ram, data bus split in/out/oe
    output ram_cmd_t          ram_cmd_o,
    output logic [DATA_W-1:0] ram_dq_o,
    output logic              ram_dq_oe_o,
    input  logic [DATA_W-1:0] ram_dq_i
);

    logic      launch;
    logic      capture;
    acc_kind_e acc_kind;

    sram_ctrl u_ctrl (
        .clk_uart_in (clk_uart_in),
        .rst_i       (rst_i),
        .if_ce_i     (if_ce_i),
        .mem_ce_i    (mem_ce_i),
        .mem_we_i    (mem_req_i.we),
        .launch_o    (launch),
        .capture_o   (capture),
        .acc_kind_o  (acc_kind)
    );

    ram_addr_path u_addr (
        .clk_uart_in (clk_uart_in),
        .rst_i       (rst_i),
        .launch_i    (launch),
        .capture_i   (capture),
        .acc_kind_i  (acc_kind),
        .if_addr_i   (if_addr_i),
        .mem_req_i   (mem_req_i),
        .ram_cmd_o   (ram_cmd_o)
    );

    ram_write_path u_wr (
        .clk_uart_in (clk_uart_in),
        .rst_i       (rst_i),
        .launch_i    (launch),
        .capture_i   (capture),
        .acc_kind_i  (acc_kind),
        .mem_wdata_i (mem_req_i.wdata),
        .ram_dq_o    (ram_dq_o),
        .ram_dq_oe_o (ram_dq_oe_o)
    );

    ram_read_latch u_rd (
        .clk_uart_in (clk_uart_in),
        .rst_i       (rst_i),
        .capture_i   (capture),
        .acc_kind_i  (acc_kind),
        .ram_dq_i    (ram_dq_i),
        .if_data_o   (if_data_o),
        .mem_data_o  (mem_data_o),
        .if_done_o   (if_done_o),
        .mem_done_o  (mem_done_o)
    );

endmodule

/* ram_read_latch.sv */
module ram_read_latch import bridge_pkg::*; (
    input  logic              clk_uart_in,
    input  logic              rst_i,
    input  logic              capture_i,
    input  acc_kind_e         acc_kind_i,
    input  logic [DATA_W-1:0] ram_dq_i,
    output logic [DATA_W-1:0] if_data_o,
    output logic [DATA_W-1:0] mem_data_o,
    output logic              if_done_o,
    output logic              mem_done_o
);

    logic [DATA_W-1:0] if_data_q;
    logic [DATA_W-1:0] mem_data_q;
    logic              if_done_q;
    logic              mem_done_q;

    // separate return registers, each kept until its port reads again
    always_ff @(posedge clk_uart_in) begin
        if (capture_i) begin
            case (acc_kind_i)
                ACC_FETCH: if_data_q  <= ram_dq_i;
                ACC_READ:  mem_data_q <= ram_dq_i;
                default: ;  // writes return nothing
            endcase
        end
    end

    // one pulse per access, for the port that asked
    always_ff @(posedge clk_uart_in) begin
        if (rst_i) begin
            if_done_q  <= 1'b0;
            mem_done_q <= 1'b0;
        end else begin
            if_done_q  <= capture_i && (acc_kind_i == ACC_FETCH);
            mem_done_q <= capture_i &&
                          (acc_kind_i == ACC_READ || acc_kind_i == ACC_WRITE);
        end
    end

    assign if_data_o  = if_data_q;
    assign mem_data_o = mem_data_q;
    assign if_done_o  = if_done_q;
    assign mem_done_o = mem_done_q;

endmodule

/* ram_write_path.sv */
module ram_write_path import bridge_pkg::*; (
    input  logic              clk_uart_in,
    input  logic              rst_i,
    input  logic              launch_i,
    input  logic              capture_i,
    input  acc_kind_e         acc_kind_i,
    input  logic [DATA_W-1:0] mem_wdata_i,
    output logic [DATA_W-1:0] ram_dq_o,
    output logic              ram_dq_oe_o
);

    logic [DATA_W-1:0] wdata_q;
    logic              dq_oe_q;
    logic              is_write;

    assign is_write = launch_i && (acc_kind_i == ACC_WRITE);

    // write word, held until the next write
    always_ff @(posedge clk_uart_in) begin
        if (is_write) begin
            wdata_q <= mem_wdata_i;
        end
    end

    // drive the bus from launch to capture, covers the we_n edge
    always_ff @(posedge clk_uart_in) begin
        if (rst_i) begin
            dq_oe_q <= 1'b0;
        end else if (is_write) begin
            dq_oe_q <= 1'b1;
        end else if (capture_i) begin
            dq_oe_q <= 1'b0;
        end
    end

    assign ram_dq_o    = wdata_q;
    assign ram_dq_oe_o = dq_oe_q;  // stands in for the tristate enable

endmodule

/* ram_addr_path.sv */
module ram_addr_path import bridge_pkg::*; (
    input  logic              clk_uart_in,
    input  logic              rst_i,
    input  logic              launch_i,
    input  logic              capture_i,
    input  acc_kind_e         acc_kind_i,
    input  logic [ADDR_W-1:0] if_addr_i,
    input  data_req_t         mem_req_i,
    output ram_cmd_t          ram_cmd_o
);

    logic [ADDR_W-1:0] addr_q;
    logic [BE_W-1:0]   be_n_q;
    logic              ce_n_q;
    logic              oe_n_q;
    logic              we_n_q;

    // address only matters while ce_n is low
    always_ff @(posedge clk_uart_in) begin
        if (launch_i) begin
            addr_q <= (acc_kind_i == ACC_FETCH) ? if_addr_i : mem_req_i.addr;
        end
    end

    always_ff @(posedge clk_uart_in) begin
        if (rst_i) begin
            be_n_q <= '1;
            ce_n_q <= 1'b1;
            oe_n_q <= 1'b1;
            we_n_q <= 1'b1;
        end else if (launch_i) begin
            be_n_q <= (acc_kind_i == ACC_FETCH) ? '0 : ~mem_req_i.be;  // fetch reads all lanes
            ce_n_q <= 1'b0;
            oe_n_q <= (acc_kind_i == ACC_WRITE);   // outputs off while we drive
            we_n_q <= (acc_kind_i != ACC_WRITE);
        end else if (capture_i) begin
            // access over, back to idle pins
            be_n_q <= '1;
            ce_n_q <= 1'b1;
            oe_n_q <= 1'b1;
            we_n_q <= 1'b1;
        end else begin
            we_n_q <= 1'b1;  // write pulse is the single command cycle
        end
    end

    assign ram_cmd_o = '{addr: addr_q, be_n: be_n_q, ce_n: ce_n_q, oe_n: oe_n_q, we_n: we_n_q};

endmodule

/* sram_ctrl.sv */
module sram_ctrl import bridge_pkg::*; (
    input  logic      clk_uart_in,
    input  logic      rst_i,
    input  logic      if_ce_i,
    input  logic      mem_ce_i,
    input  logic      mem_we_i,
    output logic      launch_o,
    output logic      capture_o,
    output acc_kind_e acc_kind_o
);

    ram_state_e state_q;
    ram_state_e state_d;
    acc_kind_e  kind_q;
    acc_kind_e  kind_d;
    logic       launch_q;
    logic       launch_d;
    logic       capture_q;
    logic       capture_d;

    // next state, strobes are one cycle wide
    always_comb begin
        state_d   = state_q;
        kind_d    = kind_q;
        launch_d  = 1'b0;
        capture_d = 1'b0;

        case (state_q)
            ST_IDLE: begin
                // data port wins, fetch waits for the next idle cycle
                if (mem_ce_i) begin
                    kind_d   = mem_we_i ? ACC_WRITE : ACC_READ;
                    state_d  = ST_ACCESS;
                    launch_d = 1'b1;
                end else if (if_ce_i) begin
                    kind_d   = ACC_FETCH;
                    state_d  = ST_ACCESS;
                    launch_d = 1'b1;
                end
            end

            ST_ACCESS: begin
                // first cycle here is the launch cycle
                // second one has the command on the pins
                if (!launch_q) begin
                    capture_d = 1'b1;
                    state_d   = ST_DONE;
                end
            end

            ST_DONE: begin
                // read latch samples at the edge that leaves this state
                state_d = ST_IDLE;
                kind_d  = ACC_NONE;
            end

            default: begin
                state_d = ST_IDLE;
                kind_d  = ACC_NONE;
            end
        endcase
    end

    always_ff @(posedge clk_uart_in) begin
        if (rst_i) begin
            state_q   <= ST_IDLE;
            kind_q    <= ACC_NONE;
            launch_q  <= 1'b0;
            capture_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            kind_q    <= kind_d;    // stable for the whole access
            launch_q  <= launch_d;
            capture_q <= capture_d;
        end
    end

    assign launch_o   = launch_q;
    assign capture_o  = capture_q;
    assign acc_kind_o = kind_q;

endmodule

/* bridge_pkg.sv */
package bridge_pkg;

    // base ram geometry
    localparam int ADDR_W = 20;  // word address
    localparam int DATA_W = 32;
    localparam int BE_W   = DATA_W / 8;

    // controller sequence, one pass per access
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_ACCESS = 2'd1,  // launch, then command on the pins
        ST_DONE   = 2'd2   // capture cycle
    } ram_state_e;

    // which port owns the current access
    typedef enum logic [1:0] {
        ACC_NONE  = 2'd0,
        ACC_FETCH = 2'd1,
        ACC_READ  = 2'd2,
        ACC_WRITE = 2'd3
    } acc_kind_e;

    // data port request, held by the core until mem_done
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [BE_W-1:0]   be;     // active-high byte select
        logic [DATA_W-1:0] wdata;
        logic              we;
    } data_req_t;

    // what the sram pins see
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [BE_W-1:0]   be_n;
        logic              ce_n;
        logic              oe_n;
        logic              we_n;
    } ram_cmd_t;

endpackage
